// ==== build.f ====
logic/core_uarch_pkg.sv
logic/core_bus_pkg.sv
logic/core_decode.sv
logic/core_uop_fifo.sv
logic/core_control_cycle.sv
logic/core_control_writeback.sv
logic/core_regfile.sv
logic/core_exec_top.sv
test/core_exec_checker.sv
test/core_exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then judge the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module core_exec_tb -o core_exec_sim
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

./obj_dir/core_exec_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation step returned an error"
	exit 1
fi

cat sim.log
if grep -q "Simulation passed" sim.log; then
	exit 0
fi
exit 1

// ==== test/core_exec_tb.sv ====
`timescale 1ns/100ps

module core_exec_tb
	import core_uarch_pkg::*;
	import core_bus_pkg::*;
();

	localparam word MEM_XOR = 32'h5a5a_0000;
	localparam int  WAIT_MAX = 400;

	logic       clk;
	logic       rst;
	logic       insn_valid;
	word        insn;
	logic       insn_ready;
	mem_req     mem;
	logic       mem_ready;
	word        mem_data_rd;
	wb_trace    wb;
	logic [1:0] flags_nz;

	integer     seed = 32'hdbb2;
	int         errors;
	int         tests;
	int         mem_delay;
	int         delay_left;
	bit         mem_hold;
	word        pc_count;
	word        exp_regs [16];
	logic [1:0] exp_flags;
	wb_trace    exp_q [$];
	string      cur_test;

	core_exec_top i_core_exec_top (.*);

	always #5 clk = ~clk;

	// ********************
	// memory model
	// ********************

	// the delay of the next request is taken while the bus is idle.
	always @(negedge clk) begin
		if (rst) begin
			mem_ready  <= 1'b0;
			delay_left <= mem_delay;
		end else if (mem_ready) begin
			mem_ready  <= 1'b0;
			delay_left <= mem_delay;
		end else if (!mem.valid) begin
			delay_left <= mem_delay;
		end else if (!mem_hold) begin
			if (delay_left == 0) begin
				mem_ready   <= 1'b1;
				mem_data_rd <= mem.addr ^ MEM_XOR;
			end else begin
				delay_left <= delay_left - 1;
			end
		end
	end

	// wb is stable around the falling edge.
	always @(negedge clk) begin
		if (!rst && wb.valid) begin
			assert (exp_q.size() != 0)
			else begin
				$display("%s: register write to r%0d with nothing expected", cur_test, wb.rd);
				errors++;
			end
			if (exp_q.size() != 0) begin
				assert (wb.rd == exp_q[0].rd && wb.value == exp_q[0].value)
				else begin
					$display("[FAIL] %s: expected r%0d=%h, actual r%0d=%h", cur_test,
						exp_q[0].rd, exp_q[0].value, wb.rd, wb.value);
					errors++;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	// ********************
	// helpers
	// ********************

	function automatic word encode(int op, int rd, int ra, bit s, int list, int imm);
		return {op[3:0], rd[3:0], ra[3:0], s, 3'b000, list[3:0], imm[11:0]};
	endfunction

	task automatic give_up(string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic expect_write(reg_num rd, word value);
		exp_q.push_back('{valid: 1'b1, rd: rd, value: value});
		exp_regs[rd] = value;
	endtask

	// returns with the word accepted, or with it still offered after limit cycles.
	task automatic offer(word w, int limit, output bit taken);
		taken = 1'b0;
		insn_valid = 1'b1;
		insn = w;
		for (int c = 0; c < limit; c++) begin
			if (insn_ready) begin
				@(posedge clk);
				taken = 1'b1;
				break;
			end
			@(negedge clk);
		end
		if (taken) begin
			pc_count = pc_count + 32'd4;
			@(negedge clk);
			insn_valid = 1'b0;
		end
	endtask

	task automatic send(word w);
		bit taken;
		offer(w, WAIT_MAX, taken);
		if (!taken)
			give_up("insn_ready");
	endtask

	task automatic send_add(int rd, int ra, bit s, int imm);
		word value;
		value = exp_regs[ra] + imm;
		expect_write(reg_num'(rd), value);
		if (s)
			exp_flags = {value[31], value == '0};
		send(encode(0, rd, ra, s, 0, imm));
	endtask

	task automatic wait_drain();
		int c;
		c = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			c++;
			if (c > WAIT_MAX)
				give_up("the expected register writes");
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic check_flags();
		assert (flags_nz == exp_flags)
		else begin
			$display("[FAIL] %s: expected nz=%b, actual nz=%b", cur_test, exp_flags, flags_nz);
			errors++;
		end
	endtask

	task automatic finish_test(int errors_before);
		tests++;
		$display("test %s done with %0d errors", cur_test, errors - errors_before);
	endtask

	// ********************
	// tests
	// ********************

	task automatic add_chain_test();
		int e;
		e = errors;
		cur_test = "add_chain";
		send_add(1, 0, 0, 5);
		send_add(2, 1, 0, 12'h10);
		send_add(3, 2, 1, 12'h20);
		wait_drain();
		check_flags();
		send_add(4, 0, 1, 0);
		wait_drain();
		check_flags();
		// a write without S leaves the flags alone.
		send_add(6, 1, 0, 12'h7);
		wait_drain();
		check_flags();
		finish_test(e);
	endtask

	task automatic ldr_test();
		int e;
		e = errors;
		cur_test = "ldr";
		mem_delay = 1 + $unsigned($random(seed)) % 5;
		expect_write(5, (exp_regs[1] + 32'h40) ^ MEM_XOR);
		send(encode(1, 5, 1, 0, 0, 12'h40));
		wait_drain();
		finish_test(e);
	endtask

	task automatic ldm_test();
		int  e;
		word base;
		e = errors;
		cur_test = "ldm";
		mem_delay = $unsigned($random(seed)) % 6;
		base = exp_regs[2];
		for (int i = 0; i < 3; i++)
			expect_write(reg_num'(8 + i), (base + 4 * i) ^ MEM_XOR);
		expect_write(2, base + 32'd12);
		send(encode(2, 8, 2, 0, 4'b0111, 0));
		wait_drain();
		finish_test(e);
	endtask

	task automatic swi_test();
		int e;
		e = errors;
		cur_test = "swi";
		expect_write(R14, pc_count + 32'd4);
		expect_write(R15, SWI_VECTOR);
		send(encode(3, 0, 0, 0, 0, 0));
		wait_drain();
		finish_test(e);
	endtask

	task automatic backpressure_test();
		int  e;
		int  sent;
		bit  taken;
		word base;
		e = errors;
		cur_test = "backpressure";
		mem_delay = $unsigned($random(seed)) % 6;
		mem_hold = 1'b1;
		base = exp_regs[3];
		expect_write(8, base ^ MEM_XOR);
		expect_write(9, (base + 32'd4) ^ MEM_XOR);
		expect_write(3, base + 32'd8);
		send(encode(2, 8, 3, 0, 4'b0011, 0));
		sent = 0;
		taken = 1'b1;
		while (taken && sent < 8) begin
			expect_write(reg_num'(11 + sent % 3), exp_regs[1] + sent + 1);
			offer(encode(0, 11 + sent % 3, 1, 0, 0, sent + 1), 6, taken);
			sent++;
		end
		assert (!taken)
		else begin
			$display("%s: insn_ready never dropped while memory was stalled", cur_test);
			errors++;
		end
		mem_hold = 1'b0;
		if (!taken)
			send(insn);
		wait_drain();
		finish_test(e);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		insn_valid = 1'b0;
		insn = '0;
		mem_ready = 1'b0;
		mem_data_rd = '0;
		mem_hold = 1'b0;
		mem_delay = 0;
		errors = 0;
		tests = 0;
		pc_count = '0;
		exp_flags = 2'b00;
		cur_test = "reset";
		for (int i = 0; i < 16; i++)
			exp_regs[i] = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		add_chain_test();
		ldr_test();
		ldm_test();
		swi_test();
		backpressure_test();

		$display("tests run: %0d, checks failed: %0d", tests, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== test/core_exec_checker.sv ====
`timescale 1ns/100ps

module core_exec_checker
	import core_uarch_pkg::*;
	import core_bus_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    insn_valid,
	input logic    insn_ready,
	input word     insn,
	input mem_req  mem,
	input logic    mem_ready,
	input wb_trace wb
);

	// an offered word must wait unchanged until it is taken.
	insn_held: assert property (@(posedge clk) disable iff (rst)
		insn_valid && !insn_ready |=> insn_valid && $stable(insn))
		else $error("instruction word changed before it was accepted");

	// a memory request keeps its address until mem_ready answers it.
	mem_held: assert property (@(posedge clk) disable iff (rst)
		mem.valid && !mem_ready |=> mem.valid && $stable(mem.addr))
		else $error("memory request changed before mem_ready");

	reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> !wb.valid && !mem.valid)
		else $error("write or memory request active right after reset");

endmodule

bind core_exec_top core_exec_checker i_core_exec_checker (.*);

// ==== logic/core_exec_top.sv ====
`timescale 1ns/100ps

module core_exec_top
	import core_uarch_pkg::*;
	import core_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       insn_valid,
	input  word        insn,
	output logic       insn_ready,

	output mem_req     mem,
	input  logic       mem_ready,
	input  word        mem_data_rd,

	output wb_trace    wb,
	output logic [1:0] flags_nz
);

	micro_op   dec_uop;
	micro_op   head_uop;
	micro_op   cur_uop;
	logic      dec_valid;
	logic      fifo_ready;
	logic      head_valid;
	logic      seq_ready;
	ctrl_cycle cycle;
	ctrl_cycle next_cycle;
	logic      issue;
	reg_num    popped;
	logic      pop_valid;
	word       saved_base;
	word       q_alu;
	reg_num    ra_sel;
	word       ra_value;
	reg_num    wr_rd;
	word       wr_value;
	logic      we;
	logic      update_flags;

	// ********************
	// producer and buffer
	// ********************

	core_decode i_core_decode (
		.clk        (clk),
		.rst        (rst),
		.insn_valid (insn_valid),
		.insn       (insn),
		.insn_ready (insn_ready),
		.uop_valid  (dec_valid),
		.uop        (dec_uop),
		.uop_ready  (fifo_ready)
	);

	core_uop_fifo i_core_uop_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (dec_valid),
		.in_uop    (dec_uop),
		.in_ready  (fifo_ready),
		.out_valid (head_valid),
		.out_uop   (head_uop),
		.out_ready (seq_ready)
	);

	// ********************
	// consumer
	// ********************

	core_control_cycle i_core_control_cycle (
		.clk        (clk),
		.rst        (rst),
		.uop_valid  (head_valid),
		.uop        (head_uop),
		.uop_ready  (seq_ready),
		.ra_value   (ra_value),
		.mem_ready  (mem_ready),
		.cycle      (cycle),
		.next_cycle (next_cycle),
		.cur_uop    (cur_uop),
		.issue      (issue),
		.popped     (popped),
		.pop_valid  (pop_valid),
		.saved_base (saved_base),
		.q_alu      (q_alu),
		.ra_sel     (ra_sel),
		.mem        (mem)
	);

	core_control_writeback i_core_control_writeback (
		.clk          (clk),
		.rst          (rst),
		.cycle        (cycle),
		.next_cycle   (next_cycle),
		.cur_uop      (cur_uop),
		.issue        (issue),
		.popped       (popped),
		.pop_valid    (pop_valid),
		.saved_base   (saved_base),
		.mem_data_rd  (mem_data_rd),
		.q_alu        (q_alu),
		.mem_ready    (mem_ready),
		.rd           (wr_rd),
		.writeback    (we),
		.update_flags (update_flags),
		.wr_value     (wr_value)
	);

	core_regfile i_core_regfile (
		.clk          (clk),
		.rst          (rst),
		.we           (we),
		.wr_rd        (wr_rd),
		.wr_value     (wr_value),
		.update_flags (update_flags),
		.rd_sel       (ra_sel),
		.rd_value     (ra_value),
		.flags_nz     (flags_nz)
	);

	// the trace mirrors the register file write port.
	assign wb = '{valid: we, rd: wr_rd, value: wr_value};

endmodule

// ==== logic/core_regfile.sv ====
`timescale 1ns/100ps

module core_regfile
	import core_uarch_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       we,
	input  reg_num     wr_rd,
	input  word        wr_value,
	input  logic       update_flags,

	input  reg_num     rd_sel,
	output word        rd_value,
	output logic [1:0] flags_nz
);

	word regs [16];

	// a write in the same cycle is forwarded to the read port.
	assign rd_value = (we && wr_rd == rd_sel) ? wr_value : regs[rd_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flags_nz <= 2'b00;
		end else if (we) begin
			regs[wr_rd] <= wr_value;
			if (update_flags)
				flags_nz <= {wr_value[31], wr_value == '0};
		end
	end

endmodule

// ==== logic/core_control_writeback.sv ====
`timescale 1ns/100ps

module core_control_writeback
	import core_uarch_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	input  ctrl_cycle cycle,
	input  ctrl_cycle next_cycle,
	input  micro_op   cur_uop,
	input  logic      issue,
	input  reg_num    popped,
	input  logic      pop_valid,
	input  word       saved_base,
	input  word       mem_data_rd,
	input  word       q_alu,
	input  logic      mem_ready,

	output reg_num    rd,
	output logic      writeback,
	output logic      update_flags,
	output word       wr_value
);

	reg_num final_rd;
	logic   final_writeback;
	logic   final_update_flags;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd                 <= '0;
			writeback          <= 1'b0;
			update_flags       <= 1'b0;
			wr_value           <= '0;
			final_rd           <= '0;
			final_writeback    <= 1'b0;
			final_update_flags <= 1'b0;
		end else begin
			writeback    <= 1'b0;
			update_flags <= 1'b0;

			// ********************
			// staging at issue
			// ********************

			// only an ADD is presented from the staged values.
			if (issue) begin
				final_rd           <= cur_uop.rd;
				final_writeback    <= cur_uop.writeback && cur_uop.op == OP_ADD;
				final_update_flags <= cur_uop.update_flags;
			end else begin
				final_writeback    <= 1'b0;
				final_update_flags <= 1'b0;
			end

			// ********************
			// per cycle writes
			// ********************

			unique case (cycle)
				ISSUE:
					if (final_writeback) begin
						rd           <= final_rd;
						writeback    <= 1'b1;
						wr_value     <= q_alu;
						update_flags <= final_update_flags;
					end

				TRANSFER:
					if (mem_ready) begin
						rd        <= pop_valid ? popped : final_rd;
						writeback <= cur_uop.writeback;
						wr_value  <= mem_data_rd;
					end

				BASE_WRITEBACK: begin
					rd        <= cur_uop.ra;
					writeback <= cur_uop.writeback;
					wr_value  <= saved_base;
				end

				EXCEPTION: begin
					writeback <= 1'b1;
					// the first exception cycle links, the second jumps.
					if (next_cycle == EXCEPTION) begin
						rd       <= R14;
						wr_value <= cur_uop.pc + 32'd4;
					end else begin
						rd       <= R15;
						wr_value <= SWI_VECTOR;
					end
				end
			endcase
		end
	end

endmodule

// ==== logic/core_control_cycle.sv ====
`timescale 1ns/100ps

module core_control_cycle
	import core_uarch_pkg::*;
	import core_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	input  logic      uop_valid,
	input  micro_op   uop,
	output logic      uop_ready,

	input  word       ra_value,
	input  logic      mem_ready,

	output ctrl_cycle cycle,
	output ctrl_cycle next_cycle,
	output micro_op   cur_uop,
	output logic      issue,
	output reg_num    popped,
	output logic      pop_valid,
	output word       saved_base,
	output word       q_alu,
	output reg_num    ra_sel,
	output mem_req    mem
);

	localparam int IDX_W = $clog2(LDM_MAX);

	micro_op            uop_q;
	logic [LDM_MAX-1:0] pending;
	logic [LDM_MAX-1:0] pending_rest;
	logic [IDX_W-1:0]   pop_idx;
	logic               first;
	logic               exc_second;
	word                addr_q;
	word                cur_addr;

	function automatic logic [IDX_W-1:0] lowest_set(input logic [LDM_MAX-1:0] list);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int i = LDM_MAX - 1; i >= 0; i--) begin
			if (list[i])
				idx = IDX_W'(i);
		end
		return idx;
	endfunction

	assign uop_ready = cycle == ISSUE;
	assign issue     = uop_valid && uop_ready;

	// the head is shown directly in its issue cycle so it can be staged.
	assign cur_uop = issue ? uop : uop_q;

	// operands are read the cycle after issue, from the latched micro-op.
	assign ra_sel = uop_q.ra;
	assign q_alu  = ra_value + uop_q.imm;

	// ********************
	// LDM register list
	// ********************

	assign pop_idx      = lowest_set(pending);
	assign pending_rest = pending & (pending - 1'b1);
	assign popped       = uop_q.rd + reg_num'(pop_idx);
	assign pop_valid    = cycle == TRANSFER && uop_q.op == OP_LDM && pending != '0;

	// the first transfer takes its address from the operand, later ones step by 4.
	assign cur_addr   = !first ? addr_q : (uop_q.op == OP_LDM ? ra_value : q_alu);
	assign saved_base = cur_addr;
	assign mem        = '{valid: cycle == TRANSFER, addr: cur_addr};

	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			ISSUE:
				if (issue) begin
					unique case (uop.op)
						OP_ADD: next_cycle = ISSUE;
						OP_LDR: next_cycle = TRANSFER;
						OP_LDM: next_cycle = uop.reg_list != '0 ? TRANSFER : BASE_WRITEBACK;
						OP_SWI: next_cycle = EXCEPTION;
					endcase
				end

			TRANSFER:
				if (mem_ready) begin
					if (uop_q.op != OP_LDM)
						next_cycle = ISSUE;
					else if (pending_rest != '0)
						next_cycle = TRANSFER;
					else
						next_cycle = BASE_WRITEBACK;
				end

			BASE_WRITEBACK:
				next_cycle = ISSUE;

			EXCEPTION:
				if (exc_second)
					next_cycle = ISSUE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle      <= ISSUE;
			uop_q      <= '0;
			pending    <= '0;
			first      <= 1'b0;
			exc_second <= 1'b0;
			addr_q     <= '0;
		end else begin
			cycle <= next_cycle;

			if (issue) begin
				uop_q   <= uop;
				pending <= uop.reg_list;
				first   <= 1'b1;
			end

			if (cycle == TRANSFER && mem_ready) begin
				pending <= pending_rest;
				first   <= 1'b0;
				addr_q  <= cur_addr + 32'd4;
			end

			if (cycle == EXCEPTION)
				exc_second <= !exc_second;
		end
	end

endmodule

// ==== logic/core_uop_fifo.sv ====
`timescale 1ns/100ps

module core_uop_fifo
	import core_uarch_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	input  logic    in_valid,
	input  micro_op in_uop,
	output logic    in_ready,

	output logic    out_valid,
	output micro_op out_uop,
	input  logic    out_ready
);

	localparam int PTR_W = $clog2(UOP_FIFO_DEPTH);
	localparam logic [PTR_W:0] COUNT_FULL = (PTR_W+1)'(UOP_FIFO_DEPTH);

	micro_op          entries [UOP_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             ready_q;
	logic             push;
	logic             pop;

	// a full buffer still takes a push when the head leaves in the same cycle.
	assign in_ready  = ready_q && (count != COUNT_FULL || out_ready);
	assign out_valid = count != '0;
	assign out_uop   = entries[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= in_uop;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/core_decode.sv ====
`timescale 1ns/100ps

module core_decode
	import core_uarch_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	input  logic    insn_valid,
	input  word     insn,
	output logic    insn_ready,

	output logic    uop_valid,
	output micro_op uop,
	input  logic    uop_ready
);

	micro_op dec;
	word     pc_count;
	logic    accept;

	// a held output is only replaced once the FIFO takes it.
	assign insn_ready = uop_ready;
	assign accept = insn_valid && insn_ready;

	always_comb begin
		case (insn[31:28])
			4'd0:    dec.op = OP_ADD;
			4'd1:    dec.op = OP_LDR;
			4'd2:    dec.op = OP_LDM;
			default: dec.op = OP_SWI;
		endcase

		dec.rd           = insn[27:24];
		dec.ra           = insn[23:20];
		dec.imm          = {20'd0, insn[11:0]};
		dec.reg_list     = insn[15:12];
		// the exception cycles force their own writes.
		dec.writeback    = dec.op != OP_SWI;
		dec.update_flags = dec.op == OP_ADD && insn[19];
		dec.pc           = pc_count;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_count  <= '0;
			uop_valid <= 1'b0;
			uop       <= '0;
		end else begin
			if (accept) begin
				uop       <= dec;
				uop_valid <= 1'b1;
				pc_count  <= pc_count + 32'd4;
			end else if (uop_ready) begin
				uop_valid <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/core_bus_pkg.sv ====
package core_bus_pkg;

	import core_uarch_pkg::*;

	// ********************
	// external ports
	// ********************

	// read request towards the memory, answered through mem_ready.
	typedef struct packed {
		logic valid;
		word  addr;
	} mem_req;

	// one entry per register file write.
	typedef struct packed {
		logic   valid;
		reg_num rd;
		word    value;
	} wb_trace;

endpackage

// ==== logic/core_uarch_pkg.sv ====
package core_uarch_pkg;

	// ********************
	// basic types
	// ********************

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	// link register and program counter.
	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

	// ********************
	// core constants
	// ********************

	localparam word SWI_VECTOR     = 32'h0000_0008;
	localparam int  UOP_FIFO_DEPTH = 4;
	localparam int  LDM_MAX        = 4;

	// control cycles walked by the sequencer.
	typedef enum logic [1:0] {
		ISSUE,
		TRANSFER,
		BASE_WRITEBACK,
		EXCEPTION
	} ctrl_cycle;

	// the encoding matches instruction bits [31:28].
	typedef enum logic [1:0] {
		OP_ADD,
		OP_LDR,
		OP_LDM,
		OP_SWI
	} uop_opcode;

	// reg_list bit i names register rd+i.
	typedef struct packed {
		uop_opcode          op;
		reg_num             rd;
		reg_num             ra;
		word                imm;
		logic [LDM_MAX-1:0] reg_list;
		logic               writeback;
		logic               update_flags;
		word                pc;
	} micro_op;

endpackage
